//--- common/cache_pkg.sv
// Cache shared types
package cache_pkg;

	// ------------------------------------------------------------------------
	// geometry
	// ------------------------------------------------------------------------
	localparam int unsigned WORD_W         = 32;
	localparam int unsigned WORDS_PER_LINE = 4;
	localparam int unsigned LINE_W         = WORD_W * WORDS_PER_LINE; // 128 bit line
	localparam int unsigned ADDR_W         = 30;                       // word address
	localparam int unsigned OFFSET_W       = 2;                        // word in line
	localparam int unsigned INDEX_W        = 3;
	localparam int unsigned NUM_LINES      = 1 << INDEX_W;             // 8 lines
	localparam int unsigned TAG_W          = ADDR_W - INDEX_W - OFFSET_W; // 25
	localparam int unsigned LINE_ADDR_W    = ADDR_W - OFFSET_W;        // tag + index, 28

	// word address split, msb first
	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic [OFFSET_W-1:0] offset;
	} word_addr_t;

	// processor request, held while stalled
	typedef struct packed {
		logic              read;
		logic              write;
		word_addr_t        addr;
		logic [WORD_W-1:0] wdata;
	} proc_req_t;

	// line request towards slow memory
	typedef struct packed {
		logic                   read;
		logic                   write;
		logic [LINE_ADDR_W-1:0] addr;
		logic [LINE_W-1:0]      wdata;
	} mem_req_t;

	// one cache entry
	typedef struct packed {
		logic              valid;
		logic              dirty;
		logic [TAG_W-1:0]  tag;
		logic [LINE_W-1:0] data;
	} line_t;

	// miss controller states
	typedef enum logic [1:0] {
		ST_COMPARE    = 2'd0, // tag check, hits served here
		ST_WRITE_BACK = 2'd1, // dirty victim out to memory
		ST_ALLOCATE   = 2'd2  // new line in from memory
	} cache_state_e;

endpackage

//--- rtl/cache/cache_ctrl.sv
// Cache miss controller
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                    clk,
	input  logic                    proc_reset,
	input  cache_pkg::proc_req_t    proc_req,
	input  logic                    hit,
	input  cache_pkg::line_t        victim,
	input  logic                    mem_done,   // accepted memory response
	output cache_pkg::cache_state_e state,
	output logic                    line_fill,
	output logic                    line_clean,
	output logic                    proc_stall
);

	cache_pkg::cache_state_e state_q;
	cache_pkg::cache_state_e state_d;
	logic                    req_active;
	logic                    miss;

	assign req_active = proc_req.read || proc_req.write;
	assign miss       = req_active && !hit;

	// ------------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------------
	always_comb begin
		state_d = state_q; // hold while memory is slow
		case (state_q)
			cache_pkg::ST_COMPARE: begin
				if (miss) begin
					// dirty victim goes out before the new line comes in
					if (victim.valid && victim.dirty) begin
						state_d = cache_pkg::ST_WRITE_BACK;
					end else begin
						state_d = cache_pkg::ST_ALLOCATE;
					end
				end
			end
			cache_pkg::ST_WRITE_BACK: begin
				if (mem_done) begin
					state_d = cache_pkg::ST_ALLOCATE;
				end
			end
			cache_pkg::ST_ALLOCATE: begin
				if (mem_done) begin
					state_d = cache_pkg::ST_COMPARE; // request hits there
				end
			end
			default: state_d = cache_pkg::ST_COMPARE; // unused code
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= cache_pkg::ST_COMPARE;
		end else begin
			state_q <= state_d;
		end
	end

	assign state      = state_q;
	assign line_clean = (state_q == cache_pkg::ST_WRITE_BACK) && mem_done;
	assign line_fill  = (state_q == cache_pkg::ST_ALLOCATE) && mem_done;

	// stall rises in the request cycle of a miss
	assign proc_stall = (state_q != cache_pkg::ST_COMPARE) || miss;

	// processor must hold its request until stall drops
	a_req_stable: assert property (
		@(posedge clk) disable iff (proc_reset)
		proc_stall |=> $stable(proc_req)
	) else $error("processor request changed while stalled");

endmodule

//--- rtl/cache/cache_store.sv
// Cache line store
`timescale 1ns/1ps

module cache_store (
	input  logic                         clk,
	input  logic                         proc_reset,
	input  cache_pkg::proc_req_t         proc_req,
	input  cache_pkg::cache_state_e      state,
	input  logic                         line_fill,  // load line from memory
	input  logic                         line_clean, // victim written back
	input  logic [cache_pkg::LINE_W-1:0] mem_rdata,
	output logic                         hit,
	output cache_pkg::line_t             victim,     // entry at request index
	output logic [cache_pkg::WORD_W-1:0] proc_rdata
);

	// ------------------------------------------------------------------------
	// arrays
	// ------------------------------------------------------------------------
	logic [cache_pkg::NUM_LINES-1:0] valid_q;
	logic [cache_pkg::NUM_LINES-1:0] dirty_q;
	logic [cache_pkg::TAG_W-1:0]     tag_q  [cache_pkg::NUM_LINES];
	logic [cache_pkg::LINE_W-1:0]    data_q [cache_pkg::NUM_LINES];

	logic [cache_pkg::INDEX_W-1:0]   idx;
	logic [cache_pkg::OFFSET_W-1:0]  off;
	logic                            wr_hit;

	assign idx = proc_req.addr.index;
	assign off = proc_req.addr.offset;

	// ------------------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------------------
	always_comb begin
		victim.valid = valid_q[idx];
		victim.dirty = dirty_q[idx];
		victim.tag   = tag_q[idx];
		victim.data  = data_q[idx];
	end

	assign hit = victim.valid && (victim.tag == proc_req.addr.tag);

	// word select, valid same cycle on a read hit
	assign proc_rdata = victim.data[off*cache_pkg::WORD_W +: cache_pkg::WORD_W];

	// write hits only land in compare
	assign wr_hit = (state == cache_pkg::ST_COMPARE) && proc_req.write && hit;

	// ------------------------------------------------------------------------
	// line status
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid_q <= '0; // every line invalid
			dirty_q <= '0;
		end else if (line_fill) begin
			valid_q[idx] <= 1'b1;
			dirty_q[idx] <= 1'b0; // fresh copy matches memory
		end else if (line_clean) begin
			dirty_q[idx] <= 1'b0;
		end else if (wr_hit) begin
			dirty_q[idx] <= 1'b1;
		end
	end

	// tag and data payload
	always_ff @(posedge clk) begin
		if (line_fill) begin
			tag_q[idx]  <= proc_req.addr.tag;
			data_q[idx] <= mem_rdata;
		end else if (wr_hit) begin
			data_q[idx][off*cache_pkg::WORD_W +: cache_pkg::WORD_W] <= proc_req.wdata;
		end
	end

	// controller never fills and cleans the same line in one cycle
	a_fill_clean_excl: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(line_fill && line_clean)
	) else $error("line fill and line clean in the same cycle");

endmodule

//--- rtl/cache/mem_port.sv
// Cache memory port
`timescale 1ns/1ps

module mem_port (
	input  logic                    clk,
	input  logic                    proc_reset,
	input  cache_pkg::cache_state_e state,
	input  cache_pkg::proc_req_t    proc_req,
	input  cache_pkg::line_t        victim,
	input  logic                    mem_ready,
	output cache_pkg::mem_req_t     mem_req,
	output logic                    mem_done  // one pulse per response
);

	logic guard_q;  // cycle after an accepted ready
	logic busy;     // transfer in progress, strobe owned
	logic in_wb;
	logic in_alloc;

	// ------------------------------------------------------------------------
	// response guard
	// ------------------------------------------------------------------------
	// memory may keep ready up one cycle past the strobe, so that cycle is
	// masked and cannot complete the next transfer
	assign busy     = (state != cache_pkg::ST_COMPARE) && !guard_q;
	assign mem_done = busy && mem_ready;

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			guard_q <= 1'b0;
		end else begin
			guard_q <= mem_done;
		end
	end

	// ------------------------------------------------------------------------
	// strobes, address, write data
	// ------------------------------------------------------------------------
	assign in_wb    = (state == cache_pkg::ST_WRITE_BACK);
	assign in_alloc = (state == cache_pkg::ST_ALLOCATE);

	always_comb begin
		// strobe drops as soon as the ready is taken
		mem_req.write = in_wb && busy && !mem_ready;
		mem_req.read  = in_alloc && busy && !mem_ready;
		if (in_wb) begin
			mem_req.addr  = {victim.tag, proc_req.addr.index}; // old line home
			mem_req.wdata = victim.data;
		end else begin
			mem_req.addr  = {proc_req.addr.tag, proc_req.addr.index};
			mem_req.wdata = '0; // quiet bus outside write-back
		end
	end

	a_strobe_excl: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write)
	) else $error("memory read and write strobes both high");

endmodule

//--- rtl/dm_cache.sv
// Direct mapped write-back cache
`timescale 1ns/1ps

module dm_cache (
	input  logic                         clk,
	input  logic                         proc_reset,
	// processor side
	input  cache_pkg::proc_req_t         proc_req,
	output logic [cache_pkg::WORD_W-1:0] proc_rdata,
	output logic                         proc_stall,
	// memory side, whole lines
	output cache_pkg::mem_req_t          mem_req,
	input  logic [cache_pkg::LINE_W-1:0] mem_rdata,
	input  logic                         mem_ready
);

	logic                    hit;
	cache_pkg::line_t        victim;
	cache_pkg::cache_state_e state;
	logic                    line_fill;
	logic                    line_clean;
	logic                    mem_done;

	// ------------------------------------------------------------------------
	// input side, tag and data arrays
	// ------------------------------------------------------------------------
	cache_store store_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.state      (state),
		.line_fill  (line_fill),
		.line_clean (line_clean),
		.mem_rdata  (mem_rdata),
		.hit        (hit),
		.victim     (victim),
		.proc_rdata (proc_rdata)
	);

	// miss sequencing
	cache_ctrl ctrl_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.hit        (hit),
		.victim     (victim),
		.mem_done   (mem_done),
		.state      (state),
		.line_fill  (line_fill),
		.line_clean (line_clean),
		.proc_stall (proc_stall)
	);

	// output side towards slow memory
	mem_port port_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.state      (state),
		.proc_req   (proc_req),
		.victim     (victim),
		.mem_ready  (mem_ready),
		.mem_req    (mem_req),
		.mem_done   (mem_done)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_dm_cache -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim.f
common/cache_pkg.sv
rtl/cache/cache_store.sv
rtl/cache/cache_ctrl.sv
rtl/cache/mem_port.sv
rtl/dm_cache.sv
tb/slow_mem_model.sv
tb/tb_dm_cache.sv

//--- tb/cache_golden.txt
// requests: op (0 read, 1 write), word addr, write data, read data, stall at start, mem writes
// first row: request count, line count; last rows: line addr, expected line (word 3 first)
15 5
0 0000000 00000000 c0de0000 1 0
0 0000003 00000000 c0de0003 0 0
0 0000006 00000000 c0de0006 1 0
1 0000001 11111111 00000000 0 0
0 0000001 00000000 11111111 0 0
1 0000002 22222222 00000000 0 0
0 0000020 00000000 c0de0020 1 1
0 0000022 00000000 c0de0022 0 0
0 0000024 00000000 c0de0024 1 0
0 0000000 00000000 c0de0000 1 0
0 0000001 00000000 11111111 0 0
0 0000002 00000000 22222222 0 0
1 0123464 deadbeef 00000000 1 0
0 0123464 00000000 deadbeef 0 0
0 0123467 00000000 c0cc3467 0 0
1 000000f 0f0f0f0f 00000000 1 0
1 000000c 0c0c0c0c 00000000 0 0
0 000002c 00000000 c0de002c 1 1
0 0000044 00000000 c0de0044 1 1
1 0000050 50505050 00000000 1 0
0 0000070 00000000 c0de0070 1 1
// final memory lines
0000000 c0de00032222222211111111c0de0000
0000003 0f0f0f0fc0de000ec0de000d0c0c0c0c
0048d19 c0cc3467c0cc3466c0cc3465deadbeef
0000014 c0de0053c0de0052c0de005150505050
0000008 c0de0023c0de0022c0de0021c0de0020

//--- tb/slow_mem_model.sv
// Slow line memory model
`timescale 1ns/1ps

module slow_mem_model (
	input  logic                         clk,
	input  logic                         proc_reset,
	input  cache_pkg::mem_req_t          mem_req,
	output logic [cache_pkg::LINE_W-1:0] mem_rdata,
	output logic                         mem_ready,
	output int                           write_count  // lines written so far
);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_WAIT,  // response delay
		PH_RESP,  // ready up
		PH_HOLD   // ready kept one extra cycle
	} phase_e;

	// only lines that were written back live here
	logic [cache_pkg::LINE_W-1:0]      lines [logic [cache_pkg::LINE_ADDR_W-1:0]];
	logic [cache_pkg::LINE_W-1:0]      rdata_q   = '0;
	logic                              ready_q   = 1'b0;
	int                                wr_cnt    = 0;
	phase_e                            phase     = PH_IDLE;
	int                                wait_cnt  = 0;
	logic                              hold_next = 1'b0;
	logic                              op_write  = 1'b0;
	logic [cache_pkg::LINE_ADDR_W-1:0] req_addr  = '0;
	logic [cache_pkg::LINE_W-1:0]      req_wdata = '0;
	integer                            seed      = 32'h3f31c5da;

	assign mem_rdata   = rdata_q;
	assign mem_ready   = ready_q;
	assign write_count = wr_cnt;

	// untouched words read as word address xor c0de0000
	function automatic logic [cache_pkg::LINE_W-1:0] line_at(
		input logic [cache_pkg::LINE_ADDR_W-1:0] addr
	);
		logic [cache_pkg::LINE_W-1:0] line;
		logic [cache_pkg::ADDR_W-1:0] waddr;
		if (lines.exists(addr)) begin
			return lines[addr];
		end
		line = '0;
		for (int w = 0; w < 4; w++) begin
			waddr = {addr, w[1:0]};
			line[w*cache_pkg::WORD_W +: cache_pkg::WORD_W] = {2'b00, waddr} ^ 32'hc0de_0000;
		end
		return line;
	endfunction

	// ------------------------------------------------------------------------
	// request sequencing, driven on the falling edge
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (proc_reset) begin
			ready_q <= 1'b0;
			phase   <= PH_IDLE;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (mem_req.read || mem_req.write) begin
						op_write  <= mem_req.write; // latch, strobe drops with ready
						req_addr  <= mem_req.addr;
						req_wdata <= mem_req.wdata;
						wait_cnt  <= ($unsigned($random(seed)) % 4) + 1; // 1 to 4 cycles
						hold_next <= ($unsigned($random(seed)) % 3) == 0;
						phase     <= PH_WAIT;
					end
				end
				PH_WAIT: begin
					if (wait_cnt > 1) begin
						wait_cnt <= wait_cnt - 1;
					end else begin
						if (op_write) begin
							lines[req_addr] = req_wdata;
							wr_cnt <= wr_cnt + 1;
						end else begin
							rdata_q <= line_at(req_addr);
						end
						ready_q <= 1'b1;
						phase   <= PH_RESP;
					end
				end
				PH_RESP: begin
					if (hold_next) begin
						phase <= PH_HOLD; // late ready, cache must mask it
					end else begin
						ready_q <= 1'b0;
						phase   <= PH_IDLE;
					end
				end
				default: begin
					ready_q <= 1'b0;
					phase   <= PH_IDLE;
				end
			endcase
		end
	end

endmodule

//--- tb/tb_dm_cache.sv
// Cache testbench
`timescale 1ns/1ps

module tb_dm_cache;

	logic                         clk = 1'b0;
	logic                         proc_reset;
	cache_pkg::proc_req_t         proc_req;
	logic [cache_pkg::WORD_W-1:0] proc_rdata;
	logic                         proc_stall;
	cache_pkg::mem_req_t          mem_req;
	logic [cache_pkg::LINE_W-1:0] mem_rdata;
	logic                         mem_ready;
	int                           mem_writes;

	logic [cache_pkg::LINE_W-1:0] golden [0:255]; // counts, requests, final lines
	int n_req;
	int n_line;
	int err_cnt     = 0;
	int strobe_errs = 0;  // strobe monitor hits
	int tests_run   = 0;
	int tests_bad   = 0;
	int cycle_cnt   = 0;
	int cycle_limit = 200;

	dm_cache dut_i (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	slow_mem_model mem_i (
		.clk         (clk),
		.proc_reset  (proc_reset),
		.mem_req     (mem_req),
		.mem_rdata   (mem_rdata),
		.mem_ready   (mem_ready),
		.write_count (mem_writes)
	);

	always #5 clk = ~clk; // 10 ns period

	// run limit grows with the request count
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, a request never completed", cycle_cnt);
			$display(">>> FAIL");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (!proc_reset && mem_req.read && mem_req.write) begin
			$display("memory read and write strobes both high at %0t", $time);
			strobe_errs <= strobe_errs + 1;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	task automatic check_word(
		input string                        name,
		input logic [cache_pkg::WORD_W-1:0] got,
		input logic [cache_pkg::WORD_W-1:0] exp
	);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_line(
		input string                        name,
		input logic [cache_pkg::LINE_W-1:0] got,
		input logic [cache_pkg::LINE_W-1:0] exp
	);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string what, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("%s ok", what);
		end else begin
			tests_bad++;
			$display("%s failed", what);
		end
	endtask

	// one request from the golden table, held until stall drops
	task automatic run_request(input int idx);
		int                           base;
		logic [3:0]                   op;
		logic [cache_pkg::WORD_W-1:0] exp_data;
		logic [cache_pkg::WORD_W-1:0] exp_stall;
		logic [cache_pkg::WORD_W-1:0] exp_writes;
		int                           writes_before;
		int                           errs_before;
		logic                         first_stall;
		base        = 2 + 6 * idx;
		op          = golden[base][3:0];
		exp_data    = golden[base + 3][31:0];
		exp_stall   = golden[base + 4][31:0];
		exp_writes  = golden[base + 5][31:0];
		errs_before = err_cnt;
		@(negedge clk);
		proc_req.read  = (op == 4'd0);
		proc_req.write = (op == 4'd1);
		proc_req.addr  = golden[base + 1][cache_pkg::ADDR_W-1:0];
		proc_req.wdata = golden[base + 2][cache_pkg::WORD_W-1:0];
		#2; // settled, well before the rising edge
		writes_before = mem_writes;
		first_stall   = proc_stall; // low means a hit
		while (proc_stall) begin
			@(negedge clk);
			#2;
		end
		if (proc_req.read) begin
			check_word("proc_rdata", proc_rdata, exp_data);
		end
		check_word("proc_stall", {31'b0, first_stall}, exp_stall);
		check_word("mem_writes", mem_writes - writes_before, exp_writes);
		report_test($sformatf("request %0d %s addr %h", idx,
			(op == 4'd1) ? "write" : "read", proc_req.addr), errs_before);
	endtask

	task automatic check_memory_line(input int idx);
		int                                base;
		int                                errs_before;
		logic [cache_pkg::LINE_ADDR_W-1:0] laddr;
		base        = 2 + 6 * n_req + 2 * idx;
		laddr       = golden[base][cache_pkg::LINE_ADDR_W-1:0];
		errs_before = err_cnt;
		check_line($sformatf("mem line %h", laddr), mem_i.line_at(laddr), golden[base + 1]);
		report_test($sformatf("memory line %h", laddr), errs_before);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		proc_reset = 1'b1;
		proc_req   = '0;
		$readmemh("tb/cache_golden.txt", golden);
		n_req       = golden[0][31:0];
		n_line      = golden[1][31:0];
		cycle_limit = 20 * n_req + 200;
		repeat (10) @(negedge clk);
		proc_reset = 1'b0;
		@(negedge clk);
		#2;
		if (mem_req.read || mem_req.write) begin
			$display("memory strobes active after reset");
			err_cnt++;
		end
		if (n_req == 0) begin
			$display("golden file missing or holds no requests");
			err_cnt++;
		end
		for (int i = 0; i < n_req; i++) begin
			run_request(i);
		end
		@(negedge clk);
		proc_req = '0; // bus idle, cache holds no dirty line now
		for (int j = 0; j < n_line; j++) begin
			check_memory_line(j);
		end
		err_cnt += strobe_errs;
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_bad, err_cnt);
		if (err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
